/* rv_pkg.sv */
// rv64i core slice shared definitions
// widths, opcode and funct encodings, alu op codes, instruction formats
package rv_pkg;

  // datapath widths
  localparam int XLEN    = 64;
  localparam int ILEN    = 32;
  localparam int RIDX_W  = 5;
  localparam int ALUOP_W = 4;

  // first fetch address
  localparam logic [XLEN-1:0] RESET_PC = '0;

  // major opcodes
  localparam logic [6:0] OPCODE_OP_IMM    = 7'b0010011;
  localparam logic [6:0] OPCODE_OP        = 7'b0110011;
  localparam logic [6:0] OPCODE_OP_IMM_32 = 7'b0011011;
  localparam logic [6:0] OPCODE_OP_32     = 7'b0111011;
  localparam logic [6:0] OPCODE_LUI       = 7'b0110111;
  localparam logic [6:0] OPCODE_AUIPC     = 7'b0010111;
  localparam logic [6:0] OPCODE_JAL       = 7'b1101111;
  localparam logic [6:0] OPCODE_JALR      = 7'b1100111;
  localparam logic [6:0] OPCODE_BRANCH    = 7'b1100011;

  // funct3 for integer ops, shared by imm and reg forms
  localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
  localparam logic [2:0] FUNCT3_SLL     = 3'b001;
  localparam logic [2:0] FUNCT3_SLT     = 3'b010;
  localparam logic [2:0] FUNCT3_XOR     = 3'b100;
  localparam logic [2:0] FUNCT3_SRL_SRA = 3'b101;
  localparam logic [2:0] FUNCT3_OR      = 3'b110;
  localparam logic [2:0] FUNCT3_AND     = 3'b111;
  // funct3 for branches
  localparam logic [2:0] FUNCT3_BEQ     = 3'b000;
  localparam logic [2:0] FUNCT3_BNE     = 3'b001;

  // funct7 for reg-reg ops, alt selects sub and sra
  localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
  localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

  // alu operation codes
  localparam logic [ALUOP_W-1:0] ALU_ADD   = 4'd0;
  localparam logic [ALUOP_W-1:0] ALU_SUB   = 4'd1;
  localparam logic [ALUOP_W-1:0] ALU_SLT   = 4'd2;
  localparam logic [ALUOP_W-1:0] ALU_XOR   = 4'd3;
  localparam logic [ALUOP_W-1:0] ALU_OR    = 4'd4;
  localparam logic [ALUOP_W-1:0] ALU_AND   = 4'd5;
  localparam logic [ALUOP_W-1:0] ALU_SLL   = 4'd6;
  localparam logic [ALUOP_W-1:0] ALU_SRL   = 4'd7;
  localparam logic [ALUOP_W-1:0] ALU_SRA   = 4'd8;
  localparam logic [ALUOP_W-1:0] ALU_PASS2 = 4'd9;

  // instruction formats, msb first
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_type_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_type_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_type_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_type_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_type_t;

  // one instruction word, every format view
  typedef union packed {
    r_type_t r;
    i_type_t i;
    s_type_t s;
    b_type_t b;
    u_type_t u;
    j_type_t j;
  } inst_u;

endpackage

/* alu.sv */
// 64-bit integer alu with rv64 word forms
// also flags operand equality for beq and bne
`timescale 1ns/1ps

module alu (
  input  logic [rv_pkg::ALUOP_W-1:0]  i_op,
  input  logic                        i_word,
  input  logic [rv_pkg::XLEN-1:0]     i_op1,
  input  logic [rv_pkg::XLEN-1:0]     i_op2,
  output logic [rv_pkg::XLEN-1:0]     o_result,
  output logic                        o_equal
);

  logic [rv_pkg::XLEN-1:0] res64;
  logic [31:0]             res32;
  // 6-bit shamt for full width, 5-bit for word ops
  logic [5:0]              sh64;
  logic [4:0]              sh32;
  logic                    lt;

  assign sh64 = i_op2[5:0];
  assign sh32 = i_op2[4:0];
  assign lt   = $signed(i_op1) < $signed(i_op2);

  // full width result
  always_comb begin
    case (i_op)
      rv_pkg::ALU_ADD:   res64 = i_op1 + i_op2;
      rv_pkg::ALU_SUB:   res64 = i_op1 - i_op2;
      rv_pkg::ALU_SLT:   res64 = {{(rv_pkg::XLEN-1){1'b0}}, lt};
      rv_pkg::ALU_XOR:   res64 = i_op1 ^ i_op2;
      rv_pkg::ALU_OR:    res64 = i_op1 | i_op2;
      rv_pkg::ALU_AND:   res64 = i_op1 & i_op2;
      rv_pkg::ALU_SLL:   res64 = i_op1 << sh64;
      rv_pkg::ALU_SRL:   res64 = i_op1 >> sh64;
      rv_pkg::ALU_SRA:   res64 = $signed(i_op1) >>> sh64;
      rv_pkg::ALU_PASS2: res64 = i_op2;
      default:           res64 = '0;
    endcase
  end

  // word forms work on the low halves only
  always_comb begin
    case (i_op)
      rv_pkg::ALU_ADD: res32 = i_op1[31:0] + i_op2[31:0];
      rv_pkg::ALU_SUB: res32 = i_op1[31:0] - i_op2[31:0];
      rv_pkg::ALU_SLL: res32 = i_op1[31:0] << sh32;
      rv_pkg::ALU_SRL: res32 = i_op1[31:0] >> sh32;
      rv_pkg::ALU_SRA: res32 = $signed(i_op1[31:0]) >>> sh32;
      default:         res32 = res64[31:0];
    endcase
  end

  // word results sign extend from bit 31
  assign o_result = i_word ? {{32{res32[31]}}, res32} : res64;
  assign o_equal  = (i_op1 == i_op2);

endmodule

/* regfile.sv */
// integer register file, 31 x 64 with x0 tied to zero
// two async read ports, one sync write port
`timescale 1ns/1ps

module regfile (
  input  logic                       clk,
  input  logic                       i_reset,
  input  logic [rv_pkg::RIDX_W-1:0]  i_rs1,
  input  logic [rv_pkg::RIDX_W-1:0]  i_rs2,
  input  logic                       i_wen,
  input  logic [rv_pkg::RIDX_W-1:0]  i_rd,
  input  logic [rv_pkg::XLEN-1:0]    i_wdata,
  output logic [rv_pkg::XLEN-1:0]    o_rs1_data,
  output logic [rv_pkg::XLEN-1:0]    o_rs2_data
);

  // x1..x31 only
  logic [rv_pkg::XLEN-1:0] regs [1:31];

  always_ff @(posedge clk) begin
    if (i_reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && (i_rd != '0)) begin
      regs[i_rd] <= i_wdata;
    end
  end

  // no bypass, a write shows up next cycle
  assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

/* id_unit.sv */
// instruction decode unit, purely combinational
// register indices, alu control, operands and branch target
`timescale 1ns/1ps

module id_unit (
  input  logic                         i_ena,
  input  rv_pkg::inst_u                i_inst,
  input  logic [rv_pkg::XLEN-1:0]      i_pc,
  input  logic [rv_pkg::XLEN-1:0]      i_rs1_data,
  input  logic [rv_pkg::XLEN-1:0]      i_rs2_data,
  output logic [rv_pkg::RIDX_W-1:0]    o_rs1,
  output logic [rv_pkg::RIDX_W-1:0]    o_rs2,
  output logic [rv_pkg::RIDX_W-1:0]    o_rd,
  output logic                         o_rd_wen,
  output logic [rv_pkg::ALUOP_W-1:0]   o_alu_op,
  output logic                         o_alu_word,
  output logic [rv_pkg::XLEN-1:0]      o_op1,
  output logic [rv_pkg::XLEN-1:0]      o_op2,
  output logic                         o_branch,
  output logic                         o_branch_ne,
  output logic                         o_jal,
  output logic                         o_jalr,
  output logic [rv_pkg::XLEN-1:0]      o_target
);

  // sign extended immediates per format
  logic [rv_pkg::XLEN-1:0] imm_i;
  logic [rv_pkg::XLEN-1:0] imm_b;
  logic [rv_pkg::XLEN-1:0] imm_u;
  logic [rv_pkg::XLEN-1:0] imm_j;
  logic [rv_pkg::XLEN-1:0] shamt;
  // selected immediate and operand muxing
  logic [rv_pkg::XLEN-1:0] imm;
  logic                    use_imm;
  logic                    op1_pc;
  // funct7 flavours
  logic                    f7_base;
  logic                    f7_alt;
  logic                    rd_wen;

  assign imm_i = {{52{i_inst.i.imm[11]}}, i_inst.i.imm};
  assign imm_b = {{51{i_inst.b.imm12}}, i_inst.b.imm12, i_inst.b.imm11,
                  i_inst.b.imm10_5, i_inst.b.imm4_1, 1'b0};
  assign imm_u = {{32{i_inst.u.imm[19]}}, i_inst.u.imm, 12'b0};
  assign imm_j = {{43{i_inst.j.imm20}}, i_inst.j.imm20, i_inst.j.imm19_12,
                  i_inst.j.imm11, i_inst.j.imm10_1, 1'b0};
  // rv64 shift-immediates carry a 6-bit shamt
  assign shamt = {58'b0, i_inst.i.imm[5:0]};

  assign f7_base = (i_inst.r.funct7 == rv_pkg::FUNCT7_BASE);
  assign f7_alt  = (i_inst.r.funct7 == rv_pkg::FUNCT7_ALT);

  // register indices, zero when disabled
  assign o_rs1 = i_ena ? i_inst.r.rs1 : '0;
  assign o_rs2 = i_ena ? i_inst.r.rs2 : '0;
  assign o_rd  = i_ena ? i_inst.r.rd  : '0;

  // control decode, depends on the instruction word only
  always_comb begin
    rd_wen      = 1'b0;
    o_alu_op    = rv_pkg::ALU_ADD;
    o_alu_word  = 1'b0;
    o_branch    = 1'b0;
    o_branch_ne = 1'b0;
    o_jal       = 1'b0;
    o_jalr      = 1'b0;
    use_imm     = 1'b0;
    op1_pc      = 1'b0;
    imm         = '0;
    if (i_ena) begin
      case (i_inst.r.opcode)
        rv_pkg::OPCODE_OP_IMM: begin
          rd_wen  = 1'b1;
          use_imm = 1'b1;
          imm     = imm_i;
          case (i_inst.i.funct3)
            rv_pkg::FUNCT3_ADD_SUB: o_alu_op = rv_pkg::ALU_ADD;
            rv_pkg::FUNCT3_SLT:     o_alu_op = rv_pkg::ALU_SLT;
            rv_pkg::FUNCT3_XOR:     o_alu_op = rv_pkg::ALU_XOR;
            rv_pkg::FUNCT3_OR:      o_alu_op = rv_pkg::ALU_OR;
            rv_pkg::FUNCT3_AND:     o_alu_op = rv_pkg::ALU_AND;
            rv_pkg::FUNCT3_SLL: begin
              o_alu_op = rv_pkg::ALU_SLL;
              imm      = shamt;
            end
            rv_pkg::FUNCT3_SRL_SRA: begin
              // inst[30] picks srai
              o_alu_op = i_inst.i.imm[10] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
              imm      = shamt;
            end
            default: rd_wen = 1'b0;
          endcase
        end
        rv_pkg::OPCODE_OP: begin
          case (i_inst.r.funct3)
            rv_pkg::FUNCT3_ADD_SUB: begin
              rd_wen   = f7_base | f7_alt;
              o_alu_op = f7_alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            end
            rv_pkg::FUNCT3_SRL_SRA: begin
              rd_wen   = f7_base | f7_alt;
              o_alu_op = f7_alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            end
            rv_pkg::FUNCT3_SLL: begin
              rd_wen   = f7_base;
              o_alu_op = rv_pkg::ALU_SLL;
            end
            rv_pkg::FUNCT3_SLT: begin
              rd_wen   = f7_base;
              o_alu_op = rv_pkg::ALU_SLT;
            end
            rv_pkg::FUNCT3_XOR: begin
              rd_wen   = f7_base;
              o_alu_op = rv_pkg::ALU_XOR;
            end
            rv_pkg::FUNCT3_OR: begin
              rd_wen   = f7_base;
              o_alu_op = rv_pkg::ALU_OR;
            end
            rv_pkg::FUNCT3_AND: begin
              rd_wen   = f7_base;
              o_alu_op = rv_pkg::ALU_AND;
            end
            default: rd_wen = 1'b0;
          endcase
        end
        // addiw only
        rv_pkg::OPCODE_OP_IMM_32: begin
          rd_wen     = (i_inst.i.funct3 == rv_pkg::FUNCT3_ADD_SUB);
          o_alu_word = 1'b1;
          use_imm    = 1'b1;
          imm        = imm_i;
        end
        // addw only
        rv_pkg::OPCODE_OP_32: begin
          rd_wen     = (i_inst.r.funct3 == rv_pkg::FUNCT3_ADD_SUB) & f7_base;
          o_alu_word = 1'b1;
        end
        rv_pkg::OPCODE_LUI: begin
          rd_wen   = 1'b1;
          o_alu_op = rv_pkg::ALU_PASS2;
          use_imm  = 1'b1;
          imm      = imm_u;
        end
        rv_pkg::OPCODE_AUIPC: begin
          rd_wen  = 1'b1;
          op1_pc  = 1'b1;
          use_imm = 1'b1;
          imm     = imm_u;
        end
        rv_pkg::OPCODE_JAL: begin
          rd_wen = 1'b1;
          o_jal  = 1'b1;
        end
        // alu forms rs1 + imm as the jump address
        rv_pkg::OPCODE_JALR: begin
          rd_wen  = 1'b1;
          o_jalr  = 1'b1;
          use_imm = 1'b1;
          imm     = imm_i;
        end
        rv_pkg::OPCODE_BRANCH: begin
          o_branch    = (i_inst.b.funct3 == rv_pkg::FUNCT3_BEQ) |
                        (i_inst.b.funct3 == rv_pkg::FUNCT3_BNE);
          o_branch_ne = (i_inst.b.funct3 == rv_pkg::FUNCT3_BNE);
        end
        // unknown opcode retires as a no-op
        default: rd_wen = 1'b0;
      endcase
    end
  end

  // writes to x0 never reach the commit port
  assign o_rd_wen = rd_wen & (i_inst.r.rd != '0);

  assign o_op1 = !i_ena ? '0 : (op1_pc ? i_pc : i_rs1_data);
  assign o_op2 = !i_ena ? '0 : (use_imm ? imm : i_rs2_data);

  // pc relative target for jal and taken branches
  assign o_target = !i_ena ? '0 :
                    (o_jal ? i_pc + imm_j : i_pc + imm_b);

endmodule

/* fetch_unit.sv */
// instruction fetch, wishbone classic read master
// holds pc and instruction, one instruction in flight
`timescale 1ns/1ps

module fetch_unit (
  input  logic                     clk,
  input  logic                     i_reset,
  input  logic                     i_wb_ack,
  input  logic [31:0]              i_wb_dat,
  input  logic [rv_pkg::XLEN-1:0]  i_next_pc,
  output logic                     o_wb_cyc,
  output logic                     o_wb_stb,
  output logic [31:0]              o_wb_adr,
  output rv_pkg::inst_u            o_inst,
  output logic [rv_pkg::XLEN-1:0]  o_pc,
  output logic                     o_inst_valid
);

  // bus busy, then one execute cycle
  typedef enum logic {
    S_BUS,
    S_EXEC
  } state_t;

  state_t                  state;
  logic                    cyc_q;
  logic [rv_pkg::XLEN-1:0] pc_q;
  rv_pkg::inst_u           inst_q;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      state <= S_BUS;
      cyc_q <= 1'b0;
      pc_q  <= rv_pkg::RESET_PC;
    end else begin
      case (state)
        S_BUS: begin
          if (cyc_q && i_wb_ack) begin
            cyc_q <= 1'b0;
            state <= S_EXEC;
          end else begin
            // first request goes out right after reset
            cyc_q <= 1'b1;
          end
        end
        S_EXEC: begin
          // retire, take the resolved pc, refetch
          pc_q  <= i_next_pc;
          cyc_q <= 1'b1;
          state <= S_BUS;
        end
        default: state <= S_BUS;
      endcase
    end
  end

  // instruction word, captured on the ack edge
  always_ff @(posedge clk) begin
    if ((state == S_BUS) && cyc_q && i_wb_ack) begin
      inst_q <= i_wb_dat;
    end
  end

  // pc only moves in execute, so adr is stable while waiting
  assign o_wb_cyc     = cyc_q;
  assign o_wb_stb     = cyc_q;
  assign o_wb_adr     = pc_q[31:0];
  assign o_inst       = inst_q;
  assign o_pc         = pc_q;
  assign o_inst_valid = (state == S_EXEC);

endmodule

/* rv_core.sv */
// rv64i core slice top, fetch then single-cycle execute
// next pc selection, register writeback and commit port
`timescale 1ns/1ps

module rv_core (
  input  logic                       clk,
  input  logic                       i_reset,
  input  logic                       i_wb_ack,
  input  logic [31:0]                i_wb_dat,
  output logic                       o_wb_cyc,
  output logic                       o_wb_stb,
  output logic [31:0]                o_wb_adr,
  output logic                       o_commit_valid,
  output logic [rv_pkg::XLEN-1:0]    o_commit_pc,
  output logic                       o_commit_wen,
  output logic [rv_pkg::RIDX_W-1:0]  o_commit_rd,
  output logic [rv_pkg::XLEN-1:0]    o_commit_data
);

  rv_pkg::inst_u              inst;
  logic [rv_pkg::XLEN-1:0]    pc;
  logic                       inst_valid;
  logic [rv_pkg::XLEN-1:0]    next_pc;
  logic [rv_pkg::XLEN-1:0]    pc_plus4;
  // decode outputs
  logic [rv_pkg::RIDX_W-1:0]  rs1;
  logic [rv_pkg::RIDX_W-1:0]  rs2;
  logic [rv_pkg::RIDX_W-1:0]  rd;
  logic                       rd_wen;
  logic [rv_pkg::ALUOP_W-1:0] alu_op;
  logic                       alu_word;
  logic [rv_pkg::XLEN-1:0]    op1;
  logic [rv_pkg::XLEN-1:0]    op2;
  logic                       branch;
  logic                       branch_ne;
  logic                       jal;
  logic                       jalr;
  logic [rv_pkg::XLEN-1:0]    target;
  // register and alu data
  logic [rv_pkg::XLEN-1:0]    rs1_data;
  logic [rv_pkg::XLEN-1:0]    rs2_data;
  logic [rv_pkg::XLEN-1:0]    alu_result;
  logic                       alu_equal;
  logic                       taken;
  logic [rv_pkg::XLEN-1:0]    wdata;

  fetch_unit u_fetch (
    .clk          (clk),
    .i_reset      (i_reset),
    .i_wb_ack     (i_wb_ack),
    .i_wb_dat     (i_wb_dat),
    .i_next_pc    (next_pc),
    .o_wb_cyc     (o_wb_cyc),
    .o_wb_stb     (o_wb_stb),
    .o_wb_adr     (o_wb_adr),
    .o_inst       (inst),
    .o_pc         (pc),
    .o_inst_valid (inst_valid)
  );

  // decode only live during the execute cycle
  id_unit u_id (
    .i_ena       (inst_valid),
    .i_inst      (inst),
    .i_pc        (pc),
    .i_rs1_data  (rs1_data),
    .i_rs2_data  (rs2_data),
    .o_rs1       (rs1),
    .o_rs2       (rs2),
    .o_rd        (rd),
    .o_rd_wen    (rd_wen),
    .o_alu_op    (alu_op),
    .o_alu_word  (alu_word),
    .o_op1       (op1),
    .o_op2       (op2),
    .o_branch    (branch),
    .o_branch_ne (branch_ne),
    .o_jal       (jal),
    .o_jalr      (jalr),
    .o_target    (target)
  );

  regfile u_rf (
    .clk        (clk),
    .i_reset    (i_reset),
    .i_rs1      (rs1),
    .i_rs2      (rs2),
    .i_wen      (rd_wen),
    .i_rd       (rd),
    .i_wdata    (wdata),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  alu u_alu (
    .i_op     (alu_op),
    .i_word   (alu_word),
    .i_op1    (op1),
    .i_op2    (op2),
    .o_result (alu_result),
    .o_equal  (alu_equal)
  );

  assign pc_plus4 = pc + 64'd4;
  // beq wants equal, bne wants not equal
  assign taken    = branch & (alu_equal ^ branch_ne);

  // jalr clears bit 0 of rs1 + imm
  assign next_pc = jalr ? {alu_result[rv_pkg::XLEN-1:1], 1'b0} :
                   (jal | taken) ? target : pc_plus4;

  // jumps link pc + 4
  assign wdata = (jal | jalr) ? pc_plus4 : alu_result;

  assign o_commit_valid = inst_valid;
  assign o_commit_pc    = pc;
  assign o_commit_wen   = rd_wen;
  assign o_commit_rd    = rd;
  assign o_commit_data  = wdata;

endmodule

/* tb_rv_core.sv */
// testbench for the rv64i core slice
// wishbone memory with random wait states and commit checks against golden records
`timescale 1ns/1ps

module tb_rv_core;

  localparam int GOLDEN_WORDS = 256;
  localparam int RESET_CYCLES = 16;
  localparam int IDLE_LIMIT   = 32;

  logic        clk;
  logic        i_reset;
  logic        i_wb_ack;
  logic [31:0] i_wb_dat;
  logic        o_wb_cyc;
  logic        o_wb_stb;
  logic [31:0] o_wb_adr;
  logic        o_commit_valid;
  logic [63:0] o_commit_pc;
  logic        o_commit_wen;
  logic [4:0]  o_commit_rd;
  logic [63:0] o_commit_data;

  // program image followed by commit records
  logic [31:0] golden [0:GOLDEN_WORDS-1];
  int          n_inst;
  int          m_count;
  // memory model state
  logic [31:0] rng_state;
  int          wait_left;
  logic        req_seen;
  // counters
  int          commit_count;
  int          idle_cycles;
  // values seen at the previous falling edge
  logic        last_cyc;
  logic [31:0] last_adr;
  logic        last_commit;
  logic        first_fetch;

  rv_core dut0 (
    .clk            (clk),
    .i_reset        (i_reset),
    .i_wb_ack       (i_wb_ack),
    .i_wb_dat       (i_wb_dat),
    .o_wb_cyc       (o_wb_cyc),
    .o_wb_stb       (o_wb_stb),
    .o_wb_adr       (o_wb_adr),
    .o_commit_valid (o_commit_valid),
    .o_commit_pc    (o_commit_pc),
    .o_commit_wen   (o_commit_wen),
    .o_commit_rd    (o_commit_rd),
    .o_commit_data  (o_commit_data)
  );

  always #10 clk = ~clk;

  // 32-bit xorshift
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic stop_on_failure();
    $display("Some tests failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(input string what);
    $display("Mismatch at %0t ns: %s", $time, what);
    stop_on_failure();
  endtask

  task automatic report_error(input string what);
    $display("Error at %0t ns: %s", $time, what);
    stop_on_failure();
  endtask

  task automatic check_reset_outputs();
    assert (!o_wb_cyc && !o_wb_stb && !o_commit_valid)
      else report_mismatch("bus or commit active during reset");
  endtask

  // wishbone handshake and commit timing
  task automatic check_bus();
    logic acked;
    // ack seen on the edge just passed
    acked = last_cyc && i_wb_ack;
    assert (o_wb_cyc == o_wb_stb)
      else report_mismatch("o_wb_cyc and o_wb_stb differ");
    if (first_fetch) begin
      assert (o_wb_cyc && o_wb_adr == 32'h0)
        else report_mismatch($sformatf("first fetch cyc %b adr %h, expected 1 and 0",
                                       o_wb_cyc, o_wb_adr));
    end else if (!last_cyc && o_wb_cyc) begin
      assert (last_commit)
        else report_mismatch("bus cycle started without a commit before it");
    end
    // request held until acknowledged
    if (last_cyc && !i_wb_ack) begin
      assert (o_wb_cyc && o_wb_adr == last_adr)
        else report_mismatch($sformatf("request changed before ack, adr %h expected %h",
                                       o_wb_adr, last_adr));
    end
    // every ack pairs with exactly one commit
    if (acked) begin
      assert (o_commit_valid && !o_wb_cyc)
        else report_mismatch("no single commit cycle right after ack");
    end else begin
      assert (!o_commit_valid)
        else report_mismatch("commit without an ack one cycle before");
    end
    if (last_commit) begin
      assert (o_wb_cyc)
        else report_mismatch("no bus cycle one cycle after commit");
    end
  endtask

  // compare one retired instruction with its record
  task automatic check_commit();
    int          base;
    logic [63:0] exp_pc;
    logic        exp_wen;
    logic [4:0]  exp_rd;
    logic [63:0] exp_data;
    if (o_commit_valid) begin
      base     = n_inst + 2 + 5 * commit_count;
      exp_pc   = {32'h0, golden[base]};
      exp_wen  = golden[base+1][0];
      exp_rd   = golden[base+2][4:0];
      exp_data = {golden[base+3], golden[base+4]};
      assert (o_commit_pc == exp_pc)
        else report_mismatch($sformatf("commit %0d pc %h, expected %h",
                                       commit_count, o_commit_pc, exp_pc));
      assert (o_commit_wen == exp_wen)
        else report_mismatch($sformatf("commit %0d wen %b, expected %b",
                                       commit_count, o_commit_wen, exp_wen));
      // rd and data only mean something with wen
      if (exp_wen) begin
        assert (o_commit_rd == exp_rd)
          else report_mismatch($sformatf("commit %0d rd %0d, expected %0d",
                                         commit_count, o_commit_rd, exp_rd));
        assert (o_commit_data == exp_data)
          else report_mismatch($sformatf("commit %0d data %h, expected %h",
                                         commit_count, o_commit_data, exp_data));
      end
      commit_count++;
      idle_cycles = 0;
    end
  endtask

  // memory slave with 0 to 3 wait cycles per request
  task automatic serve_bus();
    int word_idx;
    if (i_wb_ack) begin
      i_wb_ack = 1'b0;
      req_seen = 1'b0;
    end else if (o_wb_cyc && o_wb_stb) begin
      if (!req_seen) begin
        rng_state = xorshift32(rng_state);
        wait_left = int'(rng_state[1:0]);
        req_seen  = 1'b1;
      end
      if (wait_left == 0) begin
        word_idx = int'(o_wb_adr[31:2]);
        assert (o_wb_adr[1:0] == 2'b00 && word_idx < n_inst)
          else report_error("fetch address lies outside the program image");
        i_wb_dat = golden[1 + word_idx];
        i_wb_ack = 1'b1;
      end else begin
        wait_left--;
      end
    end
  endtask

  initial begin
    clk          = 1'b0;
    i_reset      = 1'b1;
    i_wb_ack     = 1'b0;
    i_wb_dat     = 32'h0;
    rng_state    = 32'd36118;
    wait_left    = 0;
    req_seen     = 1'b0;
    commit_count = 0;
    idle_cycles  = 0;
    last_cyc     = 1'b0;
    last_adr     = 32'h0;
    last_commit  = 1'b0;
    first_fetch  = 1'b1;
    $readmemh("rv_golden.hex", golden);
    n_inst = int'(golden[0]);
    assert (n_inst > 0 && n_inst < GOLDEN_WORDS / 2)
      else report_error("golden file is missing or has a bad program length");
    m_count = int'(golden[n_inst + 1]);
    assert (m_count > 0 && n_inst + 2 + 5 * m_count <= GOLDEN_WORDS)
      else report_error("golden file has a bad commit count");
    // outputs must stay quiet through reset
    repeat (RESET_CYCLES) begin
      @(negedge clk);
      check_reset_outputs();
    end
    i_reset = 1'b0;
    while (commit_count < m_count) begin
      @(negedge clk);
      check_bus();
      check_commit();
      serve_bus();
      last_cyc    = o_wb_cyc;
      last_adr    = o_wb_adr;
      last_commit = o_commit_valid;
      first_fetch = 1'b0;
      idle_cycles++;
      assert (idle_cycles <= IDLE_LIMIT)
        else report_error("no instruction retired within the idle limit");
    end
    $display("All tests passed");
    $finish;
  end

endmodule

/* rv_golden.hex */
// word 0 is the program length, then the instruction words from byte address 0
// then the commit count, one record per line: pc wen rd data_hi data_lo
0000001F
FFB00093 4010D113 7FFFF1B7 0031823B  // 0x00 addi srai lui addw
00708013 401102B3 0050A333 00001397  // 0x10 addi-x0 sub slt auipc
00628463 00629463 00100413 008004EF  // 0x20 beq bne skipped jal
00200413 04100513 000505E7 00300413  // 0x30 skipped addi jalr skipped
0FF0C613 0F02E693 0F00F713 FFF2A793  // 0x40 xori ori andi slti
02829813 03C0D893 00118933 0020C9B3  // 0x50 slli srli add xor
0062EA33 0020FAB3 00511B33 0050DBB3  // 0x60 or and sll srl
4050DC33 FFF20C9B 00000063           // 0x70 sra addiw beq-self
0000001D
00000000 00000001 00000001 FFFFFFFF FFFFFFFB  // addi negative imm
00000004 00000001 00000002 FFFFFFFF FFFFFFFD  // srai
00000008 00000001 00000003 00000000 7FFFF000  // lui
0000000C 00000001 00000004 FFFFFFFF FFFFE000  // addw wraps
00000010 00000000 00000000 00000000 00000000  // addi to x0
00000014 00000001 00000005 00000000 00000002
00000018 00000001 00000006 00000000 00000001
0000001C 00000001 00000007 00000000 0000101C  // auipc
00000020 00000000 00000000 00000000 00000000  // beq not taken
00000024 00000000 00000000 00000000 00000000  // bne taken
0000002C 00000001 00000009 00000000 00000030  // jal link
00000034 00000001 0000000A 00000000 00000041
00000038 00000001 0000000B 00000000 0000003C  // jalr link
00000040 00000001 0000000C FFFFFFFF FFFFFF04
00000044 00000001 0000000D 00000000 000000F2
00000048 00000001 0000000E 00000000 000000F0
0000004C 00000001 0000000F 00000000 00000000
00000050 00000001 00000010 00000200 00000000
00000054 00000001 00000011 00000000 0000000F
00000058 00000001 00000012 00000000 7FFFEFFB
0000005C 00000001 00000013 00000000 00000006
00000060 00000001 00000014 00000000 00000003
00000064 00000001 00000015 FFFFFFFF FFFFFFF9
00000068 00000001 00000016 FFFFFFFF FFFFFFF4
0000006C 00000001 00000017 3FFFFFFF FFFFFFFE
00000070 00000001 00000018 FFFFFFFF FFFFFFFE
00000074 00000001 00000019 FFFFFFFF FFFFDFFF  // addiw
00000078 00000000 00000000 00000000 00000000  // self loop
00000078 00000000 00000000 00000000 00000000

/* vlog.f */
rv_pkg.sv
alu.sv
regfile.sv
id_unit.sv
fetch_unit.sv
rv_core.sv
tb_rv_core.sv

/* run.sh */
#!/bin/sh
# build with verilator, run, then decide from the log
rm -f sim.log
verilator --binary --assert --top-module tb_rv_core -f vlog.f || exit 1
./obj_dir/Vtb_rv_core > sim.log 2>&1
grep -q "All tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
